// ==== sources.f ====
verilog/simd_pkg.sv
verilog/simd_operand_prep.sv
verilog/simd_lane_alu.sv
verilog/simd_latency_pipe.sv
verilog/simd_writeback.sv
verilog/simd_unit.sv
testbench/simd_unit_asserts.sv
testbench/tb_simd_unit.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_simd_unit
BUILD_DIR ?= obj_dir
FILELIST  ?= sources.f
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
FAIL_MSG  := Finished with errors
PASS_MSG  := Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	elif ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	else \
		echo "Simulation PASSED"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== testbench/tb_simd_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module tb_simd_unit;

    localparam time CLK_PERIOD   = 40ns;
    localparam time DRIVE_DELAY  = 2ns;   // Inputs change just after the edge
    localparam time SAMPLE_DELAY = 5ns;
    localparam int  END_TIMEOUT  = 20;

    typedef struct {
        string                 name;
        simd_pkg::simd_issue_t issue;
        logic                  is_scalar;
        simd_pkg::vec_t        exp;        // Scalar results use the low 64 bits
        int                    lat;
        int                    gap;        // Idle cycles after the issue
    } row_t;

    logic                  clk_i;
    logic                  rstn_i;
    simd_pkg::simd_issue_t instruction_i;
    simd_pkg::scalar_wb_t  instruction_scalar_o;
    simd_pkg::vector_wb_t  instruction_simd_o;

    row_t rows[$];
    int   pend_idx[$];    // Rows still waiting for their result, in arrival order
    int   pend_cycle[$];
    int   cycle;

    simd_unit i_dut (
        .clk_i                (clk_i),
        .rstn_i               (rstn_i),
        .instruction_i        (instruction_i),
        .instruction_scalar_o (instruction_scalar_o),
        .instruction_simd_o   (instruction_simd_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #(CLK_PERIOD/2) clk_i = ~clk_i;
    end

    always @(posedge clk_i) cycle <= cycle + 1;

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Finished with errors");
        $fatal(1);
    endtask

    task automatic check_vector(input string name, input simd_pkg::vector_wb_t exp,
                                input simd_pkg::vector_wb_t act);
        if (act !== exp) begin
            stop_with_error($sformatf("mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic check_scalar(input string name, input simd_pkg::scalar_wb_t exp,
                                input simd_pkg::scalar_wb_t act);
        if (act !== exp) begin
            stop_with_error($sformatf("mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic add_row(input string name, input simd_pkg::simd_op_t op,
                           input simd_pkg::sew_t sew, input simd_pkg::src_t src,
                           input logic msk, input simd_pkg::bus64_t rs1, input logic [4:0] imm,
                           input simd_pkg::vec_t vs1, input simd_pkg::vec_t vs2,
                           input simd_pkg::vec_t old, input simd_pkg::vec_t vm,
                           input logic is_sc, input simd_pkg::vec_t exp,
                           input int lat, input int gap);
        row_t r;
        r.name  = name;
        r.issue = '0;
        r.issue.op          = op;
        r.issue.sew         = sew;
        r.issue.src         = src;
        r.issue.use_mask    = msk;
        r.issue.data_rs1    = rs1;
        r.issue.imm         = imm;
        r.issue.data_vs1    = vs1;
        r.issue.data_vs2    = vs2;
        r.issue.data_old_vd = old;
        r.issue.data_vm     = vm;
        r.is_scalar = is_sc;
        r.exp       = exp;
        r.lat       = lat;
        r.gap       = gap;
        rows.push_back(r);
    endtask

    task automatic check_outputs();
        int idx;
        int cyc;
        if (instruction_scalar_o.valid || instruction_simd_o.valid) begin
            if (pend_idx.size() == 0) stop_with_error("Output valid rose with no result pending");
            idx = pend_idx.pop_front();
            cyc = pend_cycle.pop_front();
            if (cycle != cyc) begin
                stop_with_error($sformatf("Result of %s arrived in cycle %0d, expected %0d",
                                          rows[idx].name, cycle, cyc));
            end
            if (rows[idx].is_scalar) begin
                check_scalar(rows[idx].name, {1'b1, 5'(idx), rows[idx].exp[63:0]},
                             instruction_scalar_o);
            end else begin
                check_vector(rows[idx].name, {1'b1, 5'(idx), rows[idx].exp}, instruction_simd_o);
            end
        end else if (pend_idx.size() > 0 && cycle > pend_cycle[0]) begin
            stop_with_error($sformatf("Result of %s never arrived", rows[pend_idx[0]].name));
        end
    endtask

    // Monitor, outputs only depend on registered state
    initial begin
        forever begin
            @(posedge clk_i);
            #SAMPLE_DELAY;
            if (rstn_i) check_outputs();
        end
    end

    initial begin
        int waited;
        rstn_i        = 1'b0;
        instruction_i = '0;

        add_row("add8_wrap", simd_pkg::OP_VADD, simd_pkg::SEW_8, simd_pkg::SRC_VV, 1'b0, '0, '0,
                {16{8'h01}}, {8{16'h01FF}}, '0, '0, 1'b0, {8{16'h0200}}, 1, 2);
        add_row("add16_wrap", simd_pkg::OP_VADD, simd_pkg::SEW_16, simd_pkg::SRC_VV, 1'b0, '0, '0,
                {8{16'h0002}}, {8{16'hFFFF}}, '0, '0, 1'b0, {8{16'h0001}}, 1, 2);
        add_row("add64_wrap", simd_pkg::OP_VADD, simd_pkg::SEW_64, simd_pkg::SRC_VV, 1'b0, '0, '0,
                {2{64'h5}}, {2{64'hFFFF_FFFF_FFFF_FFFF}}, '0, '0, 1'b0, {2{64'h4}}, 1, 2);
        add_row("sub8", simd_pkg::OP_VSUB, simd_pkg::SEW_8, simd_pkg::SRC_VV, 1'b0, '0, '0,
                {16{8'h01}}, '0, '0, '0, 1'b0, {16{8'hFF}}, 1, 2);
        add_row("sub16", simd_pkg::OP_VSUB, simd_pkg::SEW_16, simd_pkg::SRC_VV, 1'b0, '0, '0,
                {8{16'h0001}}, {8{16'h1000}}, '0, '0, 1'b0, {8{16'h0FFF}}, 1, 2);
        add_row("sub32", simd_pkg::OP_VSUB, simd_pkg::SEW_32, simd_pkg::SRC_VV, 1'b0, '0, '0,
                {4{32'h1}}, {4{32'h0000_0100}}, '0, '0, 1'b0, {4{32'h0000_00FF}}, 1, 2);
        add_row("sub64", simd_pkg::OP_VSUB, simd_pkg::SEW_64, simd_pkg::SRC_VV, 1'b0, '0, '0,
                {2{64'h1}}, {2{64'h1_0000_0000}}, '0, '0, 1'b0, {2{64'hFFFF_FFFF}}, 1, 2);
        add_row("and16", simd_pkg::OP_VAND, simd_pkg::SEW_16, simd_pkg::SRC_VV, 1'b0, '0, '0,
                {8{16'hFF00}}, {8{16'hF0F0}}, '0, '0, 1'b0, {8{16'hF000}}, 1, 2);
        add_row("or32", simd_pkg::OP_VOR, simd_pkg::SEW_32, simd_pkg::SRC_VV, 1'b0, '0, '0,
                {8{16'h0F00}}, {8{16'hF0F0}}, '0, '0, 1'b0, {8{16'hFFF0}}, 1, 2);
        add_row("xor64", simd_pkg::OP_VXOR, simd_pkg::SEW_64, simd_pkg::SRC_VV, 1'b0, '0, '0,
                {8{16'h1234}}, {8{16'hFFFF}}, '0, '0, 1'b0, {8{16'hEDCB}}, 1, 2);
        add_row("add16_vx", simd_pkg::OP_VADD, simd_pkg::SEW_16, simd_pkg::SRC_VX, 1'b0,
                64'h1234_5678_9ABC_0003, '0, '0, {8{16'h0010}}, '0, '0, 1'b0, {8{16'h0013}}, 1, 2);
        add_row("add32_vx", simd_pkg::OP_VADD, simd_pkg::SEW_32, simd_pkg::SRC_VX, 1'b0,
                64'hDEAD_BEEF_0000_0100, '0, '0, {4{32'h1}}, '0, '0, 1'b0, {4{32'h101}}, 1, 2);
        add_row("add8_vi", simd_pkg::OP_VADD, simd_pkg::SEW_8, simd_pkg::SRC_VI, 1'b0, '0, 5'h1F,
                '0, {16{8'h10}}, '0, '0, 1'b0, {16{8'h0F}}, 1, 2);
        add_row("xor64_vi", simd_pkg::OP_VXOR, simd_pkg::SEW_64, simd_pkg::SRC_VI, 1'b0, '0, 5'h10,
                '0, '0, '0, '0, 1'b0, {2{64'hFFFF_FFFF_FFFF_FFF0}}, 1, 2);
        add_row("mul8", simd_pkg::OP_VMUL, simd_pkg::SEW_8, simd_pkg::SRC_VV, 1'b0, '0, '0,
                {16{8'h11}}, {16{8'h13}}, '0, '0, 1'b0, {16{8'h43}}, 2, 2);
        add_row("mul16", simd_pkg::OP_VMUL, simd_pkg::SEW_16, simd_pkg::SRC_VV, 1'b0, '0, '0,
                {8{16'h0101}}, {8{16'h0101}}, '0, '0, 1'b0, {8{16'h0201}}, 2, 2);
        // Back to back, both in flight at once
        add_row("mul32", simd_pkg::OP_VMUL, simd_pkg::SEW_32, simd_pkg::SRC_VV, 1'b0, '0, '0,
                {4{32'h0001_0001}}, {4{32'h0001_0000}}, '0, '0, 1'b0, {4{32'h0001_0000}}, 2, 0);
        add_row("mul64", simd_pkg::OP_VMUL, simd_pkg::SEW_64, simd_pkg::SRC_VV, 1'b0, '0, '0,
                {2{64'h1_0000_0003}}, {2{64'h1_0000_0000}}, '0, '0, 1'b0,
                {2{64'h3_0000_0000}}, 3, 2);
        add_row("mask8", simd_pkg::OP_VADD, simd_pkg::SEW_8, simd_pkg::SRC_VV, 1'b1, '0, '0,
                {16{8'h01}}, {16{8'h01}}, {16{8'hEE}}, 128'h5555, 1'b0, {8{16'hEE02}}, 1, 2);
        add_row("mask32", simd_pkg::OP_VADD, simd_pkg::SEW_32, simd_pkg::SRC_VV, 1'b1, '0, '0,
                {4{32'h1}}, {4{32'h10}}, {4{32'hCCCC_CCCC}}, 128'h6, 1'b0,
                128'hCCCC_CCCC_0000_0011_0000_0011_CCCC_CCCC, 1, 2);
        add_row("nomask64", simd_pkg::OP_VADD, simd_pkg::SEW_64, simd_pkg::SRC_VV, 1'b0, '0, '0,
                {2{64'h2}}, {2{64'h1}}, {16{8'hEE}}, '0, 1'b0, {2{64'h3}}, 1, 2);
        add_row("vmv_x_s8", simd_pkg::OP_VMV_X_S, simd_pkg::SEW_8, simd_pkg::SRC_VV, 1'b0, '0, '0,
                '0, 128'h1111_2222_3333_4444_5555_6666_7777_7780, '0, '0, 1'b1,
                {64'h0, 64'hFFFF_FFFF_FFFF_FF80}, 1, 2);
        add_row("vmv_x_s16", simd_pkg::OP_VMV_X_S, simd_pkg::SEW_16, simd_pkg::SRC_VV, 1'b0, '0,
                '0, '0, {{7{16'hFFFF}}, 16'h7FFF}, '0, '0, 1'b1,
                {64'h0, 64'h0000_0000_0000_7FFF}, 1, 2);
        add_row("vmv_x_s32", simd_pkg::OP_VMV_X_S, simd_pkg::SEW_32, simd_pkg::SRC_VV, 1'b0, '0,
                '0, '0, {96'h0, 32'h8000_0001}, '0, '0, 1'b1,
                {64'h0, 64'hFFFF_FFFF_8000_0001}, 1, 2);
        add_row("vmv_x_s64", simd_pkg::OP_VMV_X_S, simd_pkg::SEW_64, simd_pkg::SRC_VV, 1'b0, '0,
                '0, '0, 128'h1234_5678_9ABC_DEF0_8765_4321_0FED_CBA9, '0, '0, 1'b1,
                {64'h0, 64'h8765_4321_0FED_CBA9}, 1, 2);
        add_row("vmv_s_x16", simd_pkg::OP_VMV_S_X, simd_pkg::SEW_16, simd_pkg::SRC_VX, 1'b1,
                64'hFFFF_FFFF_FFFF_ABCD, '0, '0, '0, {8{16'h1111}}, '0, 1'b0,
                {{7{16'h1111}}, 16'hABCD}, 1, 2);

        repeat (10) @(posedge clk_i);
        #DRIVE_DELAY;
        rstn_i = 1'b1;
        repeat (5) @(posedge clk_i);  // Idle, the monitor flags any output

        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk_i);
            #DRIVE_DELAY;
            instruction_i       = rows[i].issue;
            instruction_i.valid = 1'b1;
            instruction_i.rd    = 5'(i);
            instruction_i.vd    = 5'(i);
            pend_idx.push_back(i);
            pend_cycle.push_back(cycle + rows[i].lat);
            repeat (rows[i].gap) begin
                @(posedge clk_i);
                #DRIVE_DELAY;
                instruction_i = '0;
            end
        end
        @(posedge clk_i);
        #DRIVE_DELAY;
        instruction_i = '0;

        waited = 0;
        while (pend_idx.size() > 0) begin
            @(posedge clk_i);
            waited++;
            if (waited > END_TIMEOUT) stop_with_error("Results still pending at the end of the run");
        end
        repeat (2) @(posedge clk_i);
        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/simd_unit_asserts.sv ====
`timescale 1ns/10ps
`default_nettype none

module simd_unit_asserts (
    input wire                        clk_i,
    input wire                        rstn_i,
    input wire simd_pkg::scalar_wb_t  instruction_scalar_o,
    input wire simd_pkg::vector_wb_t  instruction_simd_o,
    input wire [simd_pkg::MAX_LATENCY:1] tail_valid_i
);

    // Chains are cleared, so nothing may complete
    assert property (@(posedge clk_i)
        !rstn_i |-> (!instruction_scalar_o.valid && !instruction_simd_o.valid))
        else $error("Output valid high during reset");

    assert property (@(posedge clk_i) disable iff (!rstn_i)
        !(instruction_scalar_o.valid && instruction_simd_o.valid))
        else $error("Scalar and vector writeback valid together");

    // Two tails at once means one result is dropped
    assert property (@(posedge clk_i) disable iff (!rstn_i)
        $onehot0(tail_valid_i))
        else $error("Two latency chains complete in the same cycle");

endmodule

bind simd_unit simd_unit_asserts i_asserts (
    .clk_i                (clk_i),
    .rstn_i               (rstn_i),
    .instruction_scalar_o (instruction_scalar_o),
    .instruction_simd_o   (instruction_simd_o),
    .tail_valid_i         (i_latency_pipe.tail_valid)
);

`default_nettype wire

// ==== verilog/simd_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

module simd_unit (
    input  wire                          clk_i,
    input  wire                          rstn_i,
    input  wire simd_pkg::simd_issue_t   instruction_i,
    output simd_pkg::scalar_wb_t         instruction_scalar_o,
    output simd_pkg::vector_wb_t         instruction_simd_o
);

    simd_pkg::bus64_t [simd_pkg::VELEMENTS-1:0] vs1_lane;
    simd_pkg::bus64_t [simd_pkg::VELEMENTS-1:0] vs2_lane;
    simd_pkg::bus64_t [simd_pkg::VELEMENTS-1:0] lane_out;
    simd_pkg::vec_t                             lane_result;
    simd_pkg::simd_pipe_entry_t                 pipe_entry;

    simd_operand_prep i_operand_prep (
        .instruction_i (instruction_i),
        .vs1_lane_o    (vs1_lane),
        .vs2_lane_o    (vs2_lane)
    );

    for (genvar l = 0; l < simd_pkg::VELEMENTS; l++) begin : g_lane
        simd_lane_alu i_lane_alu (
            .op_i     (instruction_i.op),
            .sew_i    (instruction_i.sew),
            .vs1_i    (vs1_lane[l]),
            .vs2_i    (vs2_lane[l]),
            .result_o (lane_out[l])
        );
    end

    assign lane_result = lane_out;  // Lane 0 in the low bits

    simd_latency_pipe i_latency_pipe (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .instruction_i (instruction_i),
        .lane_result_i (lane_result),
        .entry_o       (pipe_entry)
    );

    simd_writeback i_writeback (
        .entry_i              (pipe_entry),
        .instruction_scalar_o (instruction_scalar_o),
        .instruction_simd_o   (instruction_simd_o)
    );

endmodule

`default_nettype wire

// ==== verilog/simd_writeback.sv ====
`timescale 1ns/10ps
`default_nettype none

module simd_writeback (
    input  wire simd_pkg::simd_pipe_entry_t entry_i,
    output simd_pkg::scalar_wb_t            instruction_scalar_o,
    output simd_pkg::vector_wb_t            instruction_simd_o
);

    simd_pkg::vec_t   elem_mask;   // data_vm bit i spread over element i
    simd_pkg::vec_t   masked;
    simd_pkg::vec_t   moved;       // vmv.s.x result
    simd_pkg::bus64_t scalar_res;
    logic             is_mv_x_s;
    logic             is_mv_s_x;

    assign is_mv_x_s = (entry_i.op == simd_pkg::OP_VMV_X_S);
    assign is_mv_s_x = (entry_i.op == simd_pkg::OP_VMV_S_X);

    always_comb begin
        elem_mask = '0;
        case (entry_i.sew)
            simd_pkg::SEW_8: begin
                for (int e = 0; e < simd_pkg::VLEN / 8; e++) begin
                    elem_mask[e*8 +: 8] = {8{entry_i.data_vm[e]}};
                end
            end
            simd_pkg::SEW_16: begin
                for (int e = 0; e < simd_pkg::VLEN / 16; e++) begin
                    elem_mask[e*16 +: 16] = {16{entry_i.data_vm[e]}};
                end
            end
            simd_pkg::SEW_32: begin
                for (int e = 0; e < simd_pkg::VLEN / 32; e++) begin
                    elem_mask[e*32 +: 32] = {32{entry_i.data_vm[e]}};
                end
            end
            default: begin
                for (int e = 0; e < simd_pkg::VLEN / 64; e++) begin
                    elem_mask[e*64 +: 64] = {64{entry_i.data_vm[e]}};
                end
            end
        endcase
    end

    // Disabled elements keep the old destination
    assign masked = entry_i.use_mask ?
                    ((entry_i.lane_result & elem_mask) | (entry_i.data_old_vd & ~elem_mask)) :
                    entry_i.lane_result;

    always_comb begin
        case (entry_i.sew)
            simd_pkg::SEW_8: begin
                moved      = {entry_i.data_old_vd[simd_pkg::VLEN-1:8], entry_i.lane_result[7:0]};
                scalar_res = {{56{entry_i.lane_result[7]}}, entry_i.lane_result[7:0]};
            end
            simd_pkg::SEW_16: begin
                moved      = {entry_i.data_old_vd[simd_pkg::VLEN-1:16], entry_i.lane_result[15:0]};
                scalar_res = {{48{entry_i.lane_result[15]}}, entry_i.lane_result[15:0]};
            end
            simd_pkg::SEW_32: begin
                moved      = {entry_i.data_old_vd[simd_pkg::VLEN-1:32], entry_i.lane_result[31:0]};
                scalar_res = {{32{entry_i.lane_result[31]}}, entry_i.lane_result[31:0]};
            end
            default: begin
                moved      = {entry_i.data_old_vd[simd_pkg::VLEN-1:64], entry_i.lane_result[63:0]};
                scalar_res = entry_i.lane_result[63:0];
            end
        endcase
    end

    assign instruction_scalar_o.valid  = entry_i.valid & is_mv_x_s;
    assign instruction_scalar_o.rd     = entry_i.rd;
    assign instruction_scalar_o.result = scalar_res;

    // Everything except vmv.x.s lands in the vector register file
    assign instruction_simd_o.valid   = entry_i.valid & ~is_mv_x_s;
    assign instruction_simd_o.vd      = entry_i.vd;
    assign instruction_simd_o.vresult = is_mv_s_x ? moved : masked;  // Moves ignore the mask

endmodule

`default_nettype wire

// ==== verilog/simd_latency_pipe.sv ====
`timescale 1ns/10ps
`default_nettype none

module simd_latency_pipe (
    input  wire                          clk_i,
    input  wire                          rstn_i,
    input  wire simd_pkg::simd_issue_t   instruction_i,
    input  wire simd_pkg::vec_t          lane_result_i,
    output simd_pkg::simd_pipe_entry_t   entry_o
);

    logic [1:0]                       latency;
    simd_pkg::simd_pipe_entry_t       head;
    simd_pkg::simd_pipe_entry_t       tail_entry [1:simd_pkg::MAX_LATENCY];
    logic [simd_pkg::MAX_LATENCY:1]   tail_valid;

    // Only the multiply takes more than one cycle
    always_comb begin
        if (instruction_i.op == simd_pkg::OP_VMUL) begin
            latency = (instruction_i.sew == simd_pkg::SEW_64) ? 2'd3 : 2'd2;
        end else begin
            latency = 2'd1;
        end
    end

    assign head.valid       = instruction_i.valid;
    assign head.op          = instruction_i.op;
    assign head.sew         = instruction_i.sew;
    assign head.use_mask    = instruction_i.use_mask;
    assign head.rd          = instruction_i.rd;
    assign head.vd          = instruction_i.vd;
    assign head.data_old_vd = instruction_i.data_old_vd;
    assign head.data_vm     = instruction_i.data_vm;
    assign head.lane_result = lane_result_i;

    // One chain per latency, chain l has l slots
    for (genvar l = 1; l <= simd_pkg::MAX_LATENCY; l++) begin : g_chain
        simd_pkg::simd_pipe_entry_t slot_q [l];

        always_ff @(posedge clk_i or negedge rstn_i) begin
            if (!rstn_i) begin
                for (int s = 0; s < l; s++) begin
                    slot_q[s] <= '0;
                end
            end else begin
                slot_q[0] <= (latency == 2'(l)) ? head : '0;
                for (int s = 1; s < l; s++) begin
                    slot_q[s] <= slot_q[s-1];  // Advance one slot per cycle
                end
            end
        end

        assign tail_entry[l] = slot_q[l-1];
        assign tail_valid[l] = slot_q[l-1].valid;
    end

    // Longer chains are visited last, so they win a collision
    always_comb begin
        entry_o = '0;
        for (int l = 1; l <= simd_pkg::MAX_LATENCY; l++) begin
            if (tail_valid[l]) begin
                entry_o = tail_entry[l];
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/simd_lane_alu.sv ====
`timescale 1ns/10ps
`default_nettype none

module simd_lane_alu (
    input  wire simd_pkg::simd_op_t op_i,
    input  wire simd_pkg::sew_t     sew_i,
    input  wire simd_pkg::bus64_t   vs1_i,
    input  wire simd_pkg::bus64_t   vs2_i,
    output simd_pkg::bus64_t        result_o
);

    simd_pkg::bus64_t sum;
    simd_pkg::bus64_t diff;
    simd_pkg::bus64_t prod;

    // Each element on its own, no carry crosses an element boundary
    always_comb begin
        sum  = '0;
        diff = '0;
        prod = '0;
        case (sew_i)
            simd_pkg::SEW_8: begin
                for (int e = 0; e < simd_pkg::ELEN / 8; e++) begin
                    sum[e*8 +: 8]  = vs2_i[e*8 +: 8] + vs1_i[e*8 +: 8];
                    diff[e*8 +: 8] = vs2_i[e*8 +: 8] - vs1_i[e*8 +: 8];
                    prod[e*8 +: 8] = vs2_i[e*8 +: 8] * vs1_i[e*8 +: 8];
                end
            end
            simd_pkg::SEW_16: begin
                for (int e = 0; e < simd_pkg::ELEN / 16; e++) begin
                    sum[e*16 +: 16]  = vs2_i[e*16 +: 16] + vs1_i[e*16 +: 16];
                    diff[e*16 +: 16] = vs2_i[e*16 +: 16] - vs1_i[e*16 +: 16];
                    prod[e*16 +: 16] = vs2_i[e*16 +: 16] * vs1_i[e*16 +: 16];
                end
            end
            simd_pkg::SEW_32: begin
                for (int e = 0; e < simd_pkg::ELEN / 32; e++) begin
                    sum[e*32 +: 32]  = vs2_i[e*32 +: 32] + vs1_i[e*32 +: 32];
                    diff[e*32 +: 32] = vs2_i[e*32 +: 32] - vs1_i[e*32 +: 32];
                    prod[e*32 +: 32] = vs2_i[e*32 +: 32] * vs1_i[e*32 +: 32];
                end
            end
            default: begin  // SEW_64, one element per lane
                sum  = vs2_i + vs1_i;
                diff = vs2_i - vs1_i;
                prod = vs2_i * vs1_i;  // Truncated to the low 64 bits
            end
        endcase
    end

    always_comb begin
        case (op_i)
            simd_pkg::OP_VADD:    result_o = sum;
            simd_pkg::OP_VSUB:    result_o = diff;
            simd_pkg::OP_VAND:    result_o = vs2_i & vs1_i;
            simd_pkg::OP_VOR:     result_o = vs2_i | vs1_i;
            simd_pkg::OP_VXOR:    result_o = vs2_i ^ vs1_i;
            simd_pkg::OP_VMUL:    result_o = prod;
            simd_pkg::OP_VMV_X_S: result_o = vs2_i;  // Writeback extends element 0
            simd_pkg::OP_VMV_S_X: result_o = vs1_i;  // Replicated rs1
            default:              result_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/simd_operand_prep.sv ====
`timescale 1ns/10ps
`default_nettype none

module simd_operand_prep (
    input  wire simd_pkg::simd_issue_t                      instruction_i,
    output simd_pkg::bus64_t [simd_pkg::VELEMENTS-1:0]      vs1_lane_o,
    output simd_pkg::bus64_t [simd_pkg::VELEMENTS-1:0]      vs2_lane_o
);

    simd_pkg::bus64_t scalar;     // rs1 or the extended immediate
    simd_pkg::vec_t   replica;    // scalar copied into every element
    simd_pkg::vec_t   vs1_full;

    assign scalar = (instruction_i.src == simd_pkg::SRC_VI) ?
                    {{(simd_pkg::ELEN-5){instruction_i.imm[4]}}, instruction_i.imm} :
                    instruction_i.data_rs1;

    // Replicate at the element width of the instruction
    always_comb begin
        case (instruction_i.sew)
            simd_pkg::SEW_8:  replica = {(simd_pkg::VLEN/8){scalar[7:0]}};
            simd_pkg::SEW_16: replica = {(simd_pkg::VLEN/16){scalar[15:0]}};
            simd_pkg::SEW_32: replica = {(simd_pkg::VLEN/32){scalar[31:0]}};
            default:          replica = {(simd_pkg::VLEN/64){scalar}};
        endcase
    end

    assign vs1_full = (instruction_i.src == simd_pkg::SRC_VV) ? instruction_i.data_vs1 : replica;

    // Split into lanes, lane 0 holds the low elements
    always_comb begin
        for (int l = 0; l < simd_pkg::VELEMENTS; l++) begin
            vs1_lane_o[l] = vs1_full[l*simd_pkg::ELEN +: simd_pkg::ELEN];
            vs2_lane_o[l] = instruction_i.data_vs2[l*simd_pkg::ELEN +: simd_pkg::ELEN];
        end
    end

endmodule

`default_nettype wire

// ==== verilog/simd_pkg.sv ====
`default_nettype none

package simd_pkg;

    localparam int unsigned VLEN        = 128;          // Vector register width
    localparam int unsigned ELEN        = 64;           // One lane
    localparam int unsigned VELEMENTS   = VLEN / ELEN;  // Lanes per vector
    localparam int unsigned MAX_LATENCY = 3;            // Longest chain, vmul at SEW_64

    typedef logic [ELEN-1:0] bus64_t;
    typedef logic [VLEN-1:0] vec_t;

    typedef enum logic [1:0] {
        SEW_8  = 2'b00,
        SEW_16 = 2'b01,
        SEW_32 = 2'b10,
        SEW_64 = 2'b11
    } sew_t;

    typedef enum logic [3:0] {
        OP_VADD    = 4'd0,
        OP_VSUB    = 4'd1,
        OP_VAND    = 4'd2,
        OP_VOR     = 4'd3,
        OP_VXOR    = 4'd4,
        OP_VMUL    = 4'd5,  // Low half of the product
        OP_VMV_X_S = 4'd6,  // Element 0 of vs2 to rd
        OP_VMV_S_X = 4'd7   // rs1 to element 0 of vd
    } simd_op_t;

    // Where the first operand comes from
    typedef enum logic [1:0] {
        SRC_VV = 2'b00,
        SRC_VX = 2'b01,
        SRC_VI = 2'b10
    } src_t;

    typedef struct packed {
        logic     valid;
        simd_op_t op;
        sew_t     sew;
        src_t     src;
        logic     use_mask;
        logic [4:0] rd;
        logic [4:0] vd;
        bus64_t   data_rs1;
        logic [4:0] imm;       // Signed, extended at the current SEW
        vec_t     data_vs1;
        vec_t     data_vs2;
        vec_t     data_old_vd;
        vec_t     data_vm;     // Bit i enables element i
    } simd_issue_t;

    // What travels down the latency chains
    typedef struct packed {
        logic     valid;
        simd_op_t op;
        sew_t     sew;
        logic     use_mask;
        logic [4:0] rd;
        logic [4:0] vd;
        vec_t     data_old_vd;
        vec_t     data_vm;
        vec_t     lane_result;
    } simd_pipe_entry_t;

    typedef struct packed {
        logic       valid;
        logic [4:0] rd;
        bus64_t     result;
    } scalar_wb_t;

    typedef struct packed {
        logic       valid;
        logic [4:0] vd;
        vec_t       vresult;
    } vector_wb_t;

endpackage

`default_nettype wire
